// ==== Makefile ====
TOP := tb_dehaze

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
fix_pkg.sv
pix_pkg.sv
delay_line.sv
stage_ctrl.sv
window_smooth.sv
transmission_est.sv
scene_recover.sv
dehaze_top.sv
dehaze_chk.sv
tb_dehaze.sv

// ==== dehaze_chk.sv ====
// Dehaze output checker
module dehaze_chk (
    input logic             clk,
    input logic             rst,
    input logic             in_valid,
    input pix_pkg::window_t win,
    input pix_pkg::light_t  light,
    input logic             out_valid,
    input pix_pkg::rgb_t    out_pix
);
    import pix_pkg::*;
    import fix_pkg::*;

    int         fail_count = 0;
    logic [5:0] vld_hist;
    rgb_t       exp_hist [6];
    rgb_t       prev_pix;

    // Channel c of a pixel, 0 is red
    function automatic int ch(input rgb_t p, input int c);
        logic [23:0] v;
        v = p;
        return int'(v[8*(2-c) +: 8]);
    endfunction

    // Expected output pixel for one window and light
    function automatic rgb_t model(input window_t w, input light_t l);
        logic [41:0] inv_all;
        logic [23:0] res;
        int          s [3];
        int          d;
        int          inv;
        int          haze;
        int          t;
        int          rt;
        int          a;
        int          i;
        int          m;
        inv_all = l.inv;
        for (int c = 0; c < 3; c++) begin
            s[c] = (ch(w.p1, c) + ch(w.p3, c) + ch(w.p7, c) + ch(w.p9, c)
                 + 2 * (ch(w.p2, c) + ch(w.p4, c) + ch(w.p6, c) + ch(w.p8, c))
                 + 4 * ch(w.p5, c)) / 16;
        end
        // Dark channel, ties go to red then green
        d    = (s[0] <= s[1] && s[0] <= s[2]) ? 0 : ((s[1] <= s[2]) ? 1 : 2);
        inv  = int'(inv_all[14*(2-d) +: 14]);
        inv  = inv - (inv >> OMEGA_SHIFT);
        haze = (s[d] * inv) >> 4;
        haze = (haze > HAZE_MAX) ? HAZE_MAX : haze;
        t    = 1024 - haze;
        t    = (t < T_MIN) ? T_MIN : ((t > 1023) ? 1023 : t);
        rt   = int'(recip_entry(t >> RECIP_IDX_SHIFT));
        for (int c = 0; c < 3; c++) begin
            a = ch(l.atm, c);
            i = ch(w.p5, c);
            m = (((i >= a) ? i - a : a - i) * rt) >> 8;
            m = (m > 255) ? 255 : m;
            if (i >= a) begin
                res[8*(2-c) +: 8] = 8'((a + m > 255) ? 255 : a + m);
            end else begin
                res[8*(2-c) +: 8] = 8'((m > a) ? 0 : a - m);
            end
        end
        return res;
    endfunction

    // ========================================
    // Reference history
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_hist <= '0;
        end else begin
            vld_hist <= {vld_hist[4:0], in_valid};
        end
        exp_hist[0] <= model(win, light);
        for (int k = 1; k < 6; k++) begin
            exp_hist[k] <= exp_hist[k-1];
        end
        prev_pix <= out_pix;
    end

    // ========================================
    // Assertions
    // ========================================

    a_reset: assert property (@(posedge clk) $past(rst) |-> !out_valid)
        else begin
            fail_count++;
            $error("** Error out_valid expected 0 actual %h", out_valid);
        end

    a_latency: assert property (@(posedge clk) disable iff (rst) out_valid == vld_hist[5])
        else begin
            fail_count++;
            $error("** Error out_valid expected %h actual %h", vld_hist[5], out_valid);
        end

    a_data: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_pix == exp_hist[5])
        else begin
            fail_count++;
            $error("** Error out_pix expected %h actual %h", exp_hist[5], out_pix);
        end

    a_hold: assert property (@(posedge clk) disable iff (rst) !out_valid |-> out_pix == prev_pix)
        else begin
            fail_count++;
            $error("** Error out_pix expected %h actual %h", prev_pix, out_pix);
        end

endmodule

bind dehaze_top dehaze_chk u_chk (.*);

// ==== dehaze_top.sv ====
// Dehaze pipeline top level
module dehaze_top #(
    parameter int LATENCY = 6
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  pix_pkg::window_t win,
    input  pix_pkg::light_t  light,
    output logic             out_valid,
    output pix_pkg::rgb_t    out_pix
);
    import pix_pkg::*;
    import fix_pkg::*;

    logic [LATENCY-1:0] ld;
    rgb_t               smooth;
    light_t             light_d;
    rgb_t               center_d;
    logic [RECIP_W-1:0] inv_t;

    stage_ctrl #(
        .LATENCY(LATENCY)
    ) u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .ld       (ld),
        .out_valid(out_valid)
    );

    // Stages 1 and 2
    window_smooth u_smooth (
        .clk   (clk),
        .rst   (rst),
        .ld    (ld[1:0]),
        .win   (win),
        .smooth(smooth)
    );

    delay_line #(
        .T    (light_t),
        .DEPTH(2)
    ) u_light_dly (
        .clk(clk),
        .rst(rst),
        .en (ld[1:0]),
        .d  (light),
        .q  (light_d)
    );

    delay_line #(
        .T    (rgb_t),
        .DEPTH(2)
    ) u_center_dly (
        .clk(clk),
        .rst(rst),
        .en (ld[1:0]),
        .d  (win.p5),
        .q  (center_d)
    );

    // Stages 3 to 6
    transmission_est u_trans (
        .clk      (clk),
        .rst      (rst),
        .ld       (ld[3:2]),
        .smooth   (smooth),
        .inv_light(light_d.inv),
        .inv_t    (inv_t)
    );

    scene_recover u_recover (
        .clk    (clk),
        .rst    (rst),
        .ld     (ld[5:2]),
        .center (center_d),
        .atm    (light_d.atm),
        .inv_t  (inv_t),
        .out_pix(out_pix)
    );

endmodule

// ==== delay_line.sv ====
// Enable-gated delay line
module delay_line #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [DEPTH-1:0] en,
    input  T                 d,
    output T                 q
);

    T tap [DEPTH];

    // Each tap advances with its own stage
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < DEPTH; k++) begin
                tap[k] <= '0;
            end
        end else begin
            if (en[0]) begin
                tap[0] <= d;
            end
            for (int k = 1; k < DEPTH; k++) begin
                if (en[k]) begin
                    tap[k] <= tap[k-1];
                end
            end
        end
    end

    assign q = tap[DEPTH-1];

endmodule

// ==== fix_pkg.sv ====
// Fixed-point constants
package fix_pkg;

    // Inverse light width in Q0.14
    localparam int INV_W = 14;

    // Omega is 1 minus 2^-OMEGA_SHIFT
    localparam int OMEGA_SHIFT = 4;

    // Transmission in Q1.10 where 1.0 is 1024
    localparam int TRANS_W  = 11;
    localparam int HAZE_MAX = 1023;
    localparam int T_MIN    = 128;

    // Reciprocal table indexed by the upper transmission bits
    localparam int RECIP_IDX_SHIFT = 5;
    localparam int RECIP_W         = 12;
    localparam int RECIP_NUM       = 8192;
    localparam int RECIP_MAX       = (1 << RECIP_W) - 1;

    // 1/t in Q4.8 for one table index
    function automatic logic [RECIP_W-1:0] recip_entry(input int unsigned idx);
        int unsigned q;
        if (idx == 0) begin
            return RECIP_W'(RECIP_MAX);
        end
        q = RECIP_NUM / idx;
        // Indices below the floor never get used but still need a sane value
        if (q > RECIP_MAX) begin
            q = RECIP_MAX;
        end
        return RECIP_W'(q);
    endfunction

endpackage

// ==== pix_pkg.sv ====
// Pixel and light types
package pix_pkg;

    // One colour channel
    typedef logic [7:0] chan_t;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_t;

    // 3x3 window in row order with p5 as the center
    typedef struct packed {
        rgb_t p1;
        rgb_t p2;
        rgb_t p3;
        rgb_t p4;
        rgb_t p5;
        rgb_t p6;
        rgb_t p7;
        rgb_t p8;
        rgb_t p9;
    } window_t;

    // Inverse atmospheric light in Q0.14
    typedef struct packed {
        logic [fix_pkg::INV_W-1:0] inv_r;
        logic [fix_pkg::INV_W-1:0] inv_g;
        logic [fix_pkg::INV_W-1:0] inv_b;
    } inv_light_t;

    typedef struct packed {
        rgb_t       atm;
        inv_light_t inv;
    } light_t;

endpackage

// ==== scene_recover.sv ====
// Scene radiance recovery
module scene_recover (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [3:0]                  ld,
    input  pix_pkg::rgb_t               center,
    input  pix_pkg::rgb_t               atm,
    input  logic [fix_pkg::RECIP_W-1:0] inv_t,
    output pix_pkg::rgb_t               out_pix
);
    import pix_pkg::*;
    import fix_pkg::*;

    localparam int CW     = $bits(chan_t);
    localparam int FRAC   = 8;
    localparam int PROD_W = CW + RECIP_W;

    // Per-pixel state for stages 3 to 5
    typedef struct packed {
        rgb_t       atm;
        rgb_t       mag;
        logic [2:0] ge;   // I >= A per channel, r in bit 2
    } recov_t;

    recov_t s3;
    recov_t s4;
    recov_t s5;

    function automatic chan_t abs_diff(input chan_t i, input chan_t a);
        return (i >= a) ? chan_t'(i - a) : chan_t'(a - i);
    endfunction

    // |I - A| / t with Q4.8 reciprocal, capped at 255
    function automatic chan_t scale_mag(input chan_t mag, input logic [RECIP_W-1:0] rt);
        logic [PROD_W-1:0] p;
        p = PROD_W'(mag) * PROD_W'(rt);
        if (|p[PROD_W-1:FRAC+CW]) begin
            return {CW{1'b1}};
        end
        return p[FRAC+CW-1:FRAC];
    endfunction

    function automatic chan_t combine(input chan_t a, input chan_t m, input logic ge);
        logic [CW:0] sum;
        sum = {1'b0, a} + {1'b0, m};
        if (ge) begin
            return sum[CW] ? {CW{1'b1}} : sum[CW-1:0];
        end
        return (m > a) ? '0 : chan_t'(a - m);
    endfunction

    // ========================================
    // Stages 3 to 6
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            s3      <= '0;
            s4      <= '0;
            s5      <= '0;
            out_pix <= '0;
        end else begin
            if (ld[0]) begin
                s3.atm   <= atm;
                s3.mag.r <= abs_diff(center.r, atm.r);
                s3.mag.g <= abs_diff(center.g, atm.g);
                s3.mag.b <= abs_diff(center.b, atm.b);
                s3.ge    <= {center.r >= atm.r, center.g >= atm.g, center.b >= atm.b};
            end
            // Stage 4 copy lines up with inv_t
            if (ld[1]) begin
                s4 <= s3;
            end
            // mag holds the scaled value m from here on
            if (ld[2]) begin
                s5.atm   <= s4.atm;
                s5.ge    <= s4.ge;
                s5.mag.r <= scale_mag(s4.mag.r, inv_t);
                s5.mag.g <= scale_mag(s4.mag.g, inv_t);
                s5.mag.b <= scale_mag(s4.mag.b, inv_t);
            end
            if (ld[3]) begin
                out_pix.r <= combine(s5.atm.r, s5.mag.r, s5.ge[2]);
                out_pix.g <= combine(s5.atm.g, s5.mag.g, s5.ge[1]);
                out_pix.b <= combine(s5.atm.b, s5.mag.b, s5.ge[0]);
            end
        end
    end

endmodule

// ==== stage_ctrl.sv ====
// Pipeline valid control
module stage_ctrl #(
    parameter int LATENCY = 6
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic [LATENCY-1:0] ld,
    output logic               out_valid
);

    // Valid bit per stage, bit 1 is the first register stage
    logic [LATENCY:1] vld;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld <= {vld[LATENCY-1:1], in_valid};
        end
    end

    // Stage k+1 loads while stage k holds a pixel
    assign ld        = {vld[LATENCY-1:1], in_valid};
    assign out_valid = vld[LATENCY];

endmodule

// ==== tb_dehaze.sv ====
// Dehaze pipeline testbench
module tb_dehaze;
    import pix_pkg::*;

    localparam int LATENCY   = 6;
    localparam int MAX_CYCLE = 2000;

    logic    clk = 1'b0;
    logic    rst = 1'b1;
    logic    in_valid = 1'b0;
    window_t win = '0;
    light_t  light = '0;
    logic    out_valid;
    rgb_t    out_pix;
    int      seed = 32'hd80c_5bf8;
    int      cycles = 0;
    int      mark = 0;
    int      tests_run = 0;
    int      tests_bad = 0;

    dehaze_top #(.LATENCY(LATENCY)) u_dehaze_top (.*);

    always #10 clk = ~clk;

    // Stop a stuck run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLE) begin
            $display("Timeout: run went past %0d cycles", MAX_CYCLE);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic drive(input logic v, input window_t w, input light_t l);
        @(posedge clk);
        #1;
        in_valid = v;
        win      = w;
        light    = l;
    endtask

    function automatic window_t rand_window();
        logic [223:0] v;
        for (int k = 0; k < 7; k++) begin
            v[32*k +: 32] = $random(seed);
        end
        return v[215:0];
    endfunction

    function automatic light_t rand_light();
        logic [95:0] v;
        for (int k = 0; k < 3; k++) begin
            v[32*k +: 32] = $random(seed);
        end
        return v[65:0];
    endfunction

    // Drain the pipeline, then report the assertion failures of this test
    task automatic end_test(input string name);
        int n;
        repeat (LATENCY + 1) begin
            drive(1'b0, win, light);
        end
        n    = u_dehaze_top.u_chk.fail_count - mark;
        mark = u_dehaze_top.u_chk.fail_count;
        tests_run++;
        if (n != 0) begin
            tests_bad++;
        end
        $display("%-8s %s, %0d assertion failures", name, (n == 0) ? "pass" : "fail", n);
    endtask

    initial begin
        window_t w;
        light_t  l;
        // Pixels offered while in reset must never reach the output
        in_valid = 1'b1;
        win      = rand_window();
        light    = rand_light();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        end_test("reset");

        // Back-to-back burst, then random gaps
        for (int k = 0; k < 48; k++) begin
            drive((k < 8) || ($random(seed) % 2 != 0), rand_window(), rand_light());
        end
        end_test("latency");

        for (int k = 0; k < 10; k++) begin
            l = rand_light();
            w = {9{l.atm}};
            drive(1'b1, w, l);
        end
        end_test("neutral");

        for (int k = 0; k < 300; k++) begin
            drive(1'b1, rand_window(), rand_light());
        end
        end_test("random");

        // Bright window with full inverse light drives t to the floor
        l.atm = {3{8'd100}};
        l.inv = '1;
        w     = {9{24'hff_ffff}};
        drive(1'b1, w, l);
        l.atm = {3{8'd200}};
        w.p5  = '0;
        drive(1'b1, w, l);
        end_test("clamp");

        // Isolated pixels while idle data keeps changing
        for (int k = 0; k < 4; k++) begin
            drive(1'b1, rand_window(), rand_light());
            repeat (8) begin
                drive(1'b0, rand_window(), rand_light());
            end
        end
        end_test("hold");

        $display("Tests run %0d, failed %0d", tests_run, tests_bad);
        if (tests_bad == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== transmission_est.sv ====
// Transmission estimation
module transmission_est (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [1:0]                  ld,
    input  pix_pkg::rgb_t               smooth,
    input  pix_pkg::inv_light_t         inv_light,
    output logic [fix_pkg::RECIP_W-1:0] inv_t
);
    import pix_pkg::*;
    import fix_pkg::*;

    localparam int PROD_W     = $bits(chan_t) + INV_W;
    localparam int HAZE_SHIFT = INV_W - (TRANS_W - 1);
    localparam int HAZE_W     = PROD_W - HAZE_SHIFT;
    localparam int T_ONE      = 1 << (TRANS_W - 1);
    localparam int T_MAX      = T_ONE - 1;
    localparam int IDX_W      = TRANS_W - 1 - RECIP_IDX_SHIFT;
    localparam int TBL_N      = 1 << IDX_W;

    chan_t              dark;
    logic [INV_W-1:0]   inv_sel;
    logic [INV_W-1:0]   inv_scaled;
    logic [PROD_W-1:0]  prod_q;
    logic [HAZE_W-1:0]  haze_raw;
    logic [TRANS_W-1:0] haze;
    logic [TRANS_W-1:0] t_raw;
    logic [TRANS_W-1:0] t_clamp;
    logic [IDX_W-1:0]   idx;
    logic [RECIP_W-1:0] recip_tbl [TBL_N];

    // ========================================
    // Stage 3 dark channel times omega/A
    // ========================================

    // Darkest channel wins, ties go red then green
    always_comb begin
        if (smooth.r <= smooth.g && smooth.r <= smooth.b) begin
            dark    = smooth.r;
            inv_sel = inv_light.inv_r;
        end else if (smooth.g <= smooth.b) begin
            dark    = smooth.g;
            inv_sel = inv_light.inv_g;
        end else begin
            dark    = smooth.b;
            inv_sel = inv_light.inv_b;
        end
    end

    assign inv_scaled = inv_sel - (inv_sel >> OMEGA_SHIFT);

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_q <= '0;
        end else if (ld[0]) begin
            prod_q <= PROD_W'(dark) * PROD_W'(inv_scaled);
        end
    end

    // ========================================
    // Stage 4 transmission and 1/t lookup
    // ========================================

    assign haze_raw = prod_q[PROD_W-1:HAZE_SHIFT];

    always_comb begin
        haze  = (haze_raw > HAZE_MAX) ? TRANS_W'(HAZE_MAX) : haze_raw[TRANS_W-1:0];
        t_raw = TRANS_W'(T_ONE) - haze;
        if (t_raw < T_MIN) begin
            t_clamp = TRANS_W'(T_MIN);
        end else if (t_raw > T_MAX) begin
            t_clamp = TRANS_W'(T_MAX);
        end else begin
            t_clamp = t_raw;
        end
        // Top bit of t_clamp is always clear here
        idx = t_clamp[TRANS_W-2:RECIP_IDX_SHIFT];
    end

    for (genvar i = 0; i < TBL_N; i++) begin : g_recip
        assign recip_tbl[i] = recip_entry(i);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inv_t <= '0;
        end else if (ld[1]) begin
            inv_t <= recip_tbl[idx];
        end
    end

endmodule

// ==== window_smooth.sv ====
// Gaussian window smoothing
module window_smooth (
    input  logic             clk,
    input  logic             rst,
    input  logic [1:0]       ld,
    input  pix_pkg::window_t win,
    output pix_pkg::rgb_t    smooth
);
    import pix_pkg::*;

    localparam int CW           = $bits(chan_t);
    localparam int SUM_W        = CW + 2;
    localparam int ACC_W        = CW + 4;
    localparam int KERNEL_SHIFT = 4;

    localparam logic [1:0] SEL_R = 2'd0;
    localparam logic [1:0] SEL_G = 2'd1;
    localparam logic [1:0] SEL_B = 2'd2;

    window_t win_q;

    function automatic chan_t pick(input rgb_t p, input logic [1:0] sel);
        case (sel)
            SEL_R:   return p.r;
            SEL_G:   return p.g;
            default: return p.b;
        endcase
    endfunction

    // 1-2-1 kernel, corners x1, edges x2, center x4, then /16
    function automatic chan_t gauss(input window_t w, input logic [1:0] sel);
        logic [SUM_W-1:0] corners;
        logic [SUM_W-1:0] edges;
        logic [ACC_W-1:0] acc;
        corners = SUM_W'(pick(w.p1, sel)) + SUM_W'(pick(w.p3, sel))
                + SUM_W'(pick(w.p7, sel)) + SUM_W'(pick(w.p9, sel));
        edges   = SUM_W'(pick(w.p2, sel)) + SUM_W'(pick(w.p4, sel))
                + SUM_W'(pick(w.p6, sel)) + SUM_W'(pick(w.p8, sel));
        acc     = ACC_W'(corners) + ACC_W'({edges, 1'b0}) + ACC_W'({pick(w.p5, sel), 2'b00});
        return acc[ACC_W-1:KERNEL_SHIFT];
    endfunction

    // Stage 1 window register
    always_ff @(posedge clk) begin
        if (rst) begin
            win_q <= '0;
        end else if (ld[0]) begin
            win_q <= win;
        end
    end

    // Stage 2 smoothed pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            smooth <= '0;
        end else if (ld[1]) begin
            smooth.r <= gauss(win_q, SEL_R);
            smooth.g <= gauss(win_q, SEL_G);
            smooth.b <= gauss(win_q, SEL_B);
        end
    end

endmodule
